// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      := cam_sensor_tb
FILELIST := vlog.f
OBJ_DIR  := obj_dir
LOG      := sim.log
PASS_MSG := TESTBENCH PASSED

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== logic/cam_frame_timing.sv ====
module cam_frame_timing #(
    parameter int HRES = 640,
    parameter int VRES = 480
) (
    input  logic               cam_pclk_o,
    input  logic               s_rstn,
    input  logic               en_i,
    output cam_pkg::cam_pos_t  pos_o,
    output cam_pkg::cam_sync_t sync_o
);

    // one line period in clocks, active plus blanking
    localparam int TLINE = (HRES + cam_pkg::H_BLANK_PX) * cam_pkg::BYTES_PER_PX;

    // longest vertical phase sets the delay counter width
    localparam int MAX_LINES =
        (cam_pkg::VBP_LINES > cam_pkg::VFP_LINES) ?
        ((cam_pkg::VBP_LINES > cam_pkg::VSYNC_LINES) ? cam_pkg::VBP_LINES
                                                     : cam_pkg::VSYNC_LINES) :
        ((cam_pkg::VFP_LINES > cam_pkg::VSYNC_LINES) ? cam_pkg::VFP_LINES
                                                     : cam_pkg::VSYNC_LINES);
    localparam int CNT_W = $clog2(MAX_LINES * TLINE);

    // counter loads are length minus one, the phase ends when it reads 0
    localparam int unsigned VSYNC_LOAD  = cam_pkg::VSYNC_LINES * TLINE - 1;
    localparam int unsigned VBP_LOAD    = cam_pkg::VBP_LINES * TLINE - 1;
    localparam int unsigned VFP_LOAD    = cam_pkg::VFP_LINES * TLINE - 1;
    localparam int unsigned HBLANK_LOAD = cam_pkg::H_BLANK_PX * cam_pkg::BYTES_PER_PX - 1;

    localparam int unsigned LAST_COL  = HRES - 1;
    localparam int unsigned LAST_LINE = VRES - 1;

    typedef enum logic [2:0] {
        IDLE,
        VSYNC,
        BACK_PORCH,
        LINE,
        H_BLANK,
        FRONT_PORCH
    } state_e;

    state_e                    state_q, state_d;
    logic [CNT_W-1:0]          cnt_q, cnt_d;
    logic [cam_pkg::POS_W-1:0] line_q, line_d;
    logic [cam_pkg::POS_W-1:0] col_q, col_d;
    logic                      byte_sel_q, byte_sel_d;
    logic                      frame_sel_q, frame_sel_d;
    logic                      cnt_zero;

    assign cnt_zero = (cnt_q == '0);

    always_comb begin
        state_d     = state_q;
        cnt_d       = cnt_zero ? cnt_q : cnt_q - 1'b1;
        line_d      = line_q;
        col_d       = col_q;
        byte_sel_d  = byte_sel_q;
        frame_sel_d = frame_sel_q;
        case (state_q)
            IDLE: begin
                // en_i is high here, low is handled in the register block
                state_d     = VSYNC;
                cnt_d       = VSYNC_LOAD[CNT_W-1:0];
                frame_sel_d = 1'b0;
            end
            VSYNC: begin
                if (cnt_zero) begin
                    state_d = BACK_PORCH;
                    cnt_d   = VBP_LOAD[CNT_W-1:0];
                end
            end
            BACK_PORCH: begin
                if (cnt_zero) begin
                    state_d    = LINE;
                    line_d     = '0;
                    col_d      = '0;
                    byte_sel_d = 1'b0;
                end
            end
            LINE: begin
                byte_sel_d = ~byte_sel_q;
                if (byte_sel_q) begin  // column done after its low byte
                    if (col_q == LAST_COL[cam_pkg::POS_W-1:0]) begin
                        col_d = '0;
                        if (line_q == LAST_LINE[cam_pkg::POS_W-1:0]) begin
                            state_d = FRONT_PORCH;  // no h blank after the last line
                            cnt_d   = VFP_LOAD[CNT_W-1:0];
                        end else begin
                            state_d = H_BLANK;
                            cnt_d   = HBLANK_LOAD[CNT_W-1:0];
                            line_d  = line_q + 1'b1;
                        end
                    end else begin
                        col_d = col_q + 1'b1;
                    end
                end
            end
            H_BLANK: begin
                if (cnt_zero) begin
                    state_d = LINE;
                end
            end
            FRONT_PORCH: begin
                if (cnt_zero) begin
                    state_d     = VSYNC;
                    cnt_d       = VSYNC_LOAD[CNT_W-1:0];
                    frame_sel_d = ~frame_sel_q;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge cam_pclk_o or negedge s_rstn) begin
        if (!s_rstn) begin
            state_q     <= IDLE;
            cnt_q       <= '0;
            line_q      <= '0;
            col_q       <= '0;
            byte_sel_q  <= 1'b0;
            frame_sel_q <= 1'b0;
        end else if (!en_i) begin
            state_q     <= IDLE;
            cnt_q       <= '0;
            line_q      <= '0;
            col_q       <= '0;
            byte_sel_q  <= 1'b0;
            frame_sel_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            cnt_q       <= cnt_d;
            line_q      <= line_d;
            col_q       <= col_d;
            byte_sel_q  <= byte_sel_d;
            frame_sel_q <= frame_sel_d;
        end
    end

    // outputs follow the state one clock later
    always_ff @(posedge cam_pclk_o or negedge s_rstn) begin
        if (!s_rstn) begin
            pos_o  <= '0;
            sync_o <= '0;
        end else if (!en_i) begin
            pos_o  <= '0;
            sync_o <= '0;
        end else begin
            pos_o.frame_sel <= frame_sel_q;
            pos_o.line      <= line_q;
            pos_o.col       <= col_q;
            pos_o.byte_sel  <= byte_sel_q;
            sync_o.vsync    <= (state_q == VSYNC);
            sync_o.href     <= (state_q == LINE);
        end
    end

endmodule

// ==== logic/cam_pixel_source.sv ====
module cam_pixel_source #(
    parameter int HRES = 640,
    parameter int VRES = 480
) (
    input  logic                 cam_pclk_o,
    input  logic                 s_rstn,
    input  logic                 en_i,
    input  cam_pkg::cam_pos_t    pos_i,
    input  cam_pkg::cam_sync_t   sync_i,
    output cam_pkg::cam_rgb888_t pix_o,
    output logic                 byte_sel_o,
    output cam_pkg::cam_sync_t   sync_o
);

    // integer ramp steps, they drop to 0 once the resolution exceeds 256
    localparam int unsigned R_STEP = 256 / HRES;
    localparam int unsigned G_STEP = 256 / VRES;

    logic [cam_pkg::POS_W-1:0] r_ramp;
    logic [cam_pkg::POS_W-1:0] g_ramp;
    cam_pkg::cam_rgb888_t      pattern;
    cam_pkg::cam_rgb888_t      pix_d;

    always_comb begin
        r_ramp    = pos_i.col * R_STEP[cam_pkg::POS_W-1:0];   // horizontal red ramp
        g_ramp    = pos_i.line * G_STEP[cam_pkg::POS_W-1:0];  // vertical green ramp
        pattern.r = r_ramp[7:0];
        pattern.g = g_ramp[7:0];
        pattern.b = pos_i.col[7:0] ^ pos_i.line[7:0];         // checkerboard-like blue

        // odd frames carry the inverted picture
        pix_d = pos_i.frame_sel ? ~pattern : pattern;
    end

    // pixel, byte_sel and sync travel together
    always_ff @(posedge cam_pclk_o or negedge s_rstn) begin
        if (!s_rstn) begin
            pix_o      <= '0;
            byte_sel_o <= 1'b0;
            sync_o     <= '0;
        end else if (!en_i) begin
            pix_o      <= '0;
            byte_sel_o <= 1'b0;
            sync_o     <= '0;
        end else begin
            pix_o      <= pix_d;
            byte_sel_o <= pos_i.byte_sel;
            sync_o     <= sync_i;
        end
    end

endmodule

// ==== logic/cam_pkg.sv ====
package cam_pkg;

    // horizontal blanking, in pixels, after every active line
    localparam int H_BLANK_PX = 144;

    // RGB565 goes out as two bus bytes per pixel
    localparam int BYTES_PER_PX = 2;

    // vertical phases, counted in line periods
    localparam int VSYNC_LINES = 3;
    localparam int VBP_LINES   = 17;  // back porch
    localparam int VFP_LINES   = 10;  // front porch

    // width of the line and column counters
    localparam int POS_W = 16;

    // where the timing stage currently is in the frame
    typedef struct packed {
        logic             frame_sel;  // selects the plain or inverted pattern
        logic [POS_W-1:0] line;
        logic [POS_W-1:0] col;
        logic             byte_sel;   // 0 = high byte, 1 = low byte
    } cam_pos_t;

    // strobes as the sensor puts them on the bus
    typedef struct packed {
        logic vsync;
        logic href;
    } cam_sync_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } cam_rgb888_t;

    // RGB565 word split into its colour fields
    typedef struct packed {
        logic [4:0] r5;
        logic [5:0] g6;
        logic [4:0] b5;
    } cam_rgb565_fields_t;

    // the same word as it goes out on the 8 bit bus
    typedef struct packed {
        logic [7:0] hi;  // r5 and upper g bits
        logic [7:0] lo;  // lower g bits and b5
    } cam_rgb565_bytes_t;

    // written as colour fields, read back as bus bytes
    typedef union packed {
        cam_rgb565_fields_t fields;
        cam_rgb565_bytes_t  bytes;
    } cam_rgb565_u;

endpackage

// ==== logic/cam_rgb565_packer.sv ====
module cam_rgb565_packer (
    input  logic                 cam_pclk_o,
    input  logic                 s_rstn,
    input  logic                 en_i,
    input  cam_pkg::cam_rgb888_t pix_i,
    input  logic                 byte_sel_i,
    input  cam_pkg::cam_sync_t   sync_i,
    output logic [7:0]           cam_data_o,
    output logic                 cam_vsync_o,
    output logic                 cam_href_o
);

    cam_pkg::cam_rgb565_u rgb565;
    logic [7:0]           data_d;

    always_comb begin
        // keep the top bits of each channel
        rgb565.fields.r5 = pix_i.r[7:3];
        rgb565.fields.g6 = pix_i.g[7:2];
        rgb565.fields.b5 = pix_i.b[7:3];

        if (!sync_i.href) begin
            data_d = 8'h00;  // bus is quiet during blanking
        end else if (byte_sel_i) begin
            data_d = rgb565.bytes.lo;
        end else begin
            data_d = rgb565.bytes.hi;
        end
    end

    always_ff @(posedge cam_pclk_o or negedge s_rstn) begin
        if (!s_rstn) begin
            cam_data_o  <= 8'h00;
            cam_vsync_o <= 1'b0;
            cam_href_o  <= 1'b0;
        end else if (!en_i) begin
            cam_data_o  <= 8'h00;
            cam_vsync_o <= 1'b0;
            cam_href_o  <= 1'b0;
        end else begin
            cam_data_o  <= data_d;
            cam_vsync_o <= sync_i.vsync;
            cam_href_o  <= sync_i.href;
        end
    end

endmodule

// ==== logic/cam_sensor_top.sv ====
module cam_sensor_top #(
    parameter int HRES = 640,
    parameter int VRES = 480
) (
    input  logic       cam_pclk_o,
    input  logic       s_rstn,
    input  logic       en_i,
    output logic [7:0] cam_data_o,
    output logic       cam_vsync_o,
    output logic       cam_href_o
);

    cam_pkg::cam_pos_t    timing_pos;
    cam_pkg::cam_sync_t   timing_sync;
    cam_pkg::cam_rgb888_t src_pix;
    logic                 src_byte_sel;
    cam_pkg::cam_sync_t   src_sync;

    // frame position and strobes
    cam_frame_timing #(
        .HRES(HRES),
        .VRES(VRES)
    ) u_cam_frame_timing (
        .cam_pclk_o(cam_pclk_o),
        .s_rstn    (s_rstn),
        .en_i      (en_i),
        .pos_o     (timing_pos),
        .sync_o    (timing_sync)
    );

    // test pattern, one clock behind timing
    cam_pixel_source #(
        .HRES(HRES),
        .VRES(VRES)
    ) u_cam_pixel_source (
        .cam_pclk_o(cam_pclk_o),
        .s_rstn    (s_rstn),
        .en_i      (en_i),
        .pos_i     (timing_pos),
        .sync_i    (timing_sync),
        .pix_o     (src_pix),
        .byte_sel_o(src_byte_sel),
        .sync_o    (src_sync)
    );

    // RGB565 bytes onto the bus
    cam_rgb565_packer u_cam_rgb565_packer (
        .cam_pclk_o (cam_pclk_o),
        .s_rstn     (s_rstn),
        .en_i       (en_i),
        .pix_i      (src_pix),
        .byte_sel_i (src_byte_sel),
        .sync_i     (src_sync),
        .cam_data_o (cam_data_o),
        .cam_vsync_o(cam_vsync_o),
        .cam_href_o (cam_href_o)
    );

endmodule

// ==== verif/cam_sensor_checker.sv ====
module cam_sensor_checker #(
    parameter int HRES = 640,
    parameter int VRES = 480
) (
    input  logic       cam_pclk_o,
    input  logic       s_rstn,
    input  logic       en_i,
    input  logic [7:0] data_i,
    input  logic       vsync_i,
    input  logic       href_i,
    output int         frames_done_o,
    output int         bytes_checked_o,
    output int         data_errs_o,
    output int         timing_errs_o,
    output int         idle_errs_o
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TLINE       = (HRES + cam_pkg::H_BLANK_PX) * cam_pkg::BYTES_PER_PX;
    localparam int VSYNC_CLKS  = cam_pkg::VSYNC_LINES * TLINE;
    localparam int VBP_CLKS    = cam_pkg::VBP_LINES * TLINE;
    localparam int VFP_CLKS    = cam_pkg::VFP_LINES * TLINE;
    localparam int HREF_CLKS   = HRES * cam_pkg::BYTES_PER_PX;
    localparam int HBLANK_CLKS = cam_pkg::H_BLANK_PX * cam_pkg::BYTES_PER_PX;
    localparam int START_LAG   = 3;  // enable edge to vsync high
    localparam int OFF_LAG     = 3;  // en_i low to idle outputs

    typedef enum {WAIT_VSYNC, IN_VSYNC, IN_VBP, IN_LINE, IN_HBLANK, IN_VFP} phase_e;

    phase_e phase = WAIT_VSYNC;
    int cyc = 0;
    int rst_samples = 0;
    int en_rise_cyc = 0;
    int fall_age = OFF_LAG;  // samples since en_i fell
    logic en_prev = 1'b0;
    int run_len = 0;
    int line_idx = 0;
    int byte_idx = 0;
    int frame_idx = 0;       // frames since enable, picks the pattern
    int frame_bytes = 0;     // bytes of the frame in progress
    int frames_done = 0;
    int bytes_checked = 0;
    int data_errs = 0;
    int timing_errs = 0;
    int idle_errs = 0;

    assign frames_done_o   = frames_done;
    assign bytes_checked_o = bytes_checked;
    assign data_errs_o     = data_errs;
    assign timing_errs_o   = timing_errs;
    assign idle_errs_o     = idle_errs;

    // expected bus byte for one pixel position
    function automatic logic [7:0] ref_byte(input logic frame_sel, input int line,
                                            input int col, input logic byte_sel);
        int r;
        int g;
        int b;
        logic [7:0] r8;
        logic [7:0] g8;
        logic [7:0] b8;
        r = col * (256 / HRES);
        g = line * (256 / VRES);
        b = col ^ line;
        r8 = r[7:0];
        g8 = g[7:0];
        b8 = b[7:0];
        if (frame_sel) begin  // odd frames are inverted
            r8 = ~r8;
            g8 = ~g8;
            b8 = ~b8;
        end
        if (byte_sel) begin
            return {g8[4:2], b8[7:3]};
        end
        return {r8[7:3], g8[7:5]};  // high byte first
    endfunction

    task automatic score_byte();
        logic [7:0] exp;
        string      name;
        exp = ref_byte(frame_idx[0], line_idx, byte_idx / 2, byte_idx[0]);
        frame_bytes++;
        if (data_i !== exp) begin
            data_errs++;
            name = $sformatf("pixel_data frame %0d line %0d col %0d byte %0d",
                             frame_idx, line_idx, byte_idx / 2, byte_idx % 2);
            $display("Fail %s: expected %02h, actual %02h", name, exp, data_i);
        end
        byte_idx++;
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            timing_errs++;
            $display("Fail %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_quiet(input string where);
        if (vsync_i || href_i || data_i != 8'h00) begin
            idle_errs++;
            $display("outputs not idle %s: vsync %b href %b data %02h",
                     where, vsync_i, href_i, data_i);
        end
    endtask

    task automatic start_frame();
        phase       = IN_VSYNC;
        run_len     = 1;
        line_idx    = 0;
        frame_bytes = 0;
    endtask

    task automatic track_phase();
        case (phase)
            WAIT_VSYNC: begin
                if (vsync_i) begin
                    // a sample shows the bus as it was one clock earlier
                    check_count("vsync_delay", START_LAG, cyc - en_rise_cyc - 1);
                    start_frame();
                end else begin
                    check_quiet("before the first vsync");
                end
            end
            IN_VSYNC: begin
                if (vsync_i) begin
                    run_len++;
                end else begin
                    check_count("vsync_width", VSYNC_CLKS, run_len);
                    phase   = IN_VBP;
                    run_len = 1;
                end
            end
            IN_VBP: begin
                if (href_i) begin
                    check_count("back_porch", VBP_CLKS, run_len);
                    phase    = IN_LINE;
                    byte_idx = 0;
                    score_byte();
                end else begin
                    run_len++;
                end
            end
            IN_LINE: begin
                if (href_i) begin
                    score_byte();
                end else begin
                    check_count("href_width", HREF_CLKS, byte_idx);
                    line_idx++;
                    run_len = 1;
                    phase   = (line_idx == VRES) ? IN_VFP : IN_HBLANK;
                end
            end
            IN_HBLANK: begin
                if (href_i) begin
                    check_count("h_blank", HBLANK_CLKS, run_len);
                    phase    = IN_LINE;
                    byte_idx = 0;
                    score_byte();
                end else if (vsync_i) begin
                    timing_errs++;
                    $display("vsync came after %0d of %0d lines", line_idx, VRES);
                    start_frame();
                end else begin
                    run_len++;
                end
            end
            IN_VFP: begin
                if (vsync_i) begin
                    check_count("front_porch", VFP_CLKS, run_len);
                    frames_done++;
                    bytes_checked += frame_bytes;  // only whole frames count
                    frame_idx++;
                    start_frame();
                end else if (href_i) begin
                    timing_errs++;
                    $display("href pulse after the last line of frame %0d", frame_idx);
                end else begin
                    run_len++;
                end
            end
        endcase
    endtask

    always @(posedge cam_pclk_o) begin
        cyc++;
        if (!s_rstn) begin
            rst_samples++;
            if (rst_samples > 1) begin  // regs settle on the first reset edge
                check_quiet("during reset");
            end
            phase     = WAIT_VSYNC;
            frame_idx = 0;
            en_prev   = 1'b0;
            fall_age  = OFF_LAG;
        end else if (!en_i) begin
            if (en_prev) begin
                fall_age = 0;
            end
            if (fall_age >= OFF_LAG) begin
                check_quiet("with en_i low");
            end
            phase     = WAIT_VSYNC;  // a cut frame is dropped
            frame_idx = 0;
            en_prev   = 1'b0;
        end else begin
            if (!en_prev) begin
                en_rise_cyc = cyc;
            end
            en_prev = 1'b1;
            if (fall_age >= OFF_LAG) begin
                track_phase();
            end
        end
        if (fall_age < OFF_LAG) begin
            fall_age++;
        end
    end

endmodule

// ==== verif/cam_sensor_sva.sv ====
module cam_sensor_sva (
    input logic       cam_pclk_o,
    input logic       s_rstn,
    input logic       en_i,
    input logic [7:0] data_i,
    input logic       vsync_i,
    input logic       href_i
);
    timeunit 1ns;
    timeprecision 1ps;

    int excl_fails  = 0;
    int quiet_fails = 0;
    int off_fails   = 0;
    int fail_cnt;

    assign fail_cnt = excl_fails + quiet_fails + off_fails;

    // the sensor never raises both strobes at once
    sync_exclusive: assert property (
        @(posedge cam_pclk_o) disable iff (!s_rstn) !(vsync_i && href_i)
    ) else begin
        excl_fails++;
        $error("vsync and href are high in the same clock");
    end

    data_quiet: assert property (
        @(posedge cam_pclk_o) disable iff (!s_rstn) !href_i |-> (data_i == 8'h00)
    ) else begin
        quiet_fails++;  // blanking must leave the bus at 0
        $error("data is not 0 while href is low");
    end

    // three clocks after a low en_i sample the strobes are down
    strobes_off: assert property (
        @(posedge cam_pclk_o) disable iff (!s_rstn) !en_i |-> ##3 (!vsync_i && !href_i)
    ) else begin
        off_fails++;
        $error("strobes still active 3 clocks after en_i went low");
    end

endmodule

bind cam_sensor_top cam_sensor_sva u_cam_sensor_sva (
    .cam_pclk_o(cam_pclk_o),
    .s_rstn    (s_rstn),
    .en_i      (en_i),
    .data_i    (cam_data_o),
    .vsync_i   (cam_vsync_o),
    .href_i    (cam_href_o)
);

// ==== verif/cam_sensor_tb.sv ====
module cam_sensor_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HRES  = 16;
    localparam int VRES  = 6;
    localparam int SEED  = 66247;
    localparam int TLINE = (HRES + cam_pkg::H_BLANK_PX) * cam_pkg::BYTES_PER_PX;
    localparam int FRAME_CLKS = (cam_pkg::VSYNC_LINES + cam_pkg::VBP_LINES
                                 + cam_pkg::VFP_LINES + VRES) * TLINE;
    localparam int HREF_CLKS = HRES * cam_pkg::BYTES_PER_PX;
    localparam int TIMEOUT_CLKS    = 5 * FRAME_CLKS + 2400;  // four frames, a cut one, margin
    localparam int FRAMES_TO_SCORE = 3;                      // frames 0 and 1, then the restart
    localparam int BYTES_TO_SCORE  = FRAMES_TO_SCORE * VRES * HREF_CLKS;

    logic       cam_pclk_o;
    logic       s_rstn;
    logic       en_i;
    logic [7:0] cam_data;
    logic       cam_vsync;
    logic       cam_href;

    int frames_done;
    int bytes_checked;
    int data_errs;
    int timing_errs;
    int idle_errs;
    int assert_fails;
    int cycle_cnt = 0;

    assign assert_fails = u_cam_sensor_top.u_cam_sensor_sva.fail_cnt;

    cam_sensor_top #(
        .HRES(HRES),
        .VRES(VRES)
    ) u_cam_sensor_top (
        .cam_pclk_o (cam_pclk_o),
        .s_rstn     (s_rstn),
        .en_i       (en_i),
        .cam_data_o (cam_data),
        .cam_vsync_o(cam_vsync),
        .cam_href_o (cam_href)
    );

    cam_sensor_checker #(
        .HRES(HRES),
        .VRES(VRES)
    ) u_cam_sensor_checker (
        .cam_pclk_o     (cam_pclk_o),
        .s_rstn         (s_rstn),
        .en_i           (en_i),
        .data_i         (cam_data),
        .vsync_i        (cam_vsync),
        .href_i         (cam_href),
        .frames_done_o  (frames_done),
        .bytes_checked_o(bytes_checked),
        .data_errs_o    (data_errs),
        .timing_errs_o  (timing_errs),
        .idle_errs_o    (idle_errs)
    );

    initial begin
        cam_pclk_o = 1'b0;
        forever #2 cam_pclk_o = ~cam_pclk_o;
    end

    always @(posedge cam_pclk_o) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CLKS) begin
            $display("timeout after %0d clocks with %0d of %0d frames finished",
                     cycle_cnt, frames_done, FRAMES_TO_SCORE);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic wait_vsync_rises(input int n);
        int seen;
        seen = 0;
        while (seen < n) begin
            @(posedge cam_vsync);
            seen++;
        end
    endtask

    task automatic finish_run();
        int byte_errs;
        int total;
        byte_errs = (bytes_checked == BYTES_TO_SCORE) ? 0 : 1;
        if (byte_errs != 0) begin
            $display("Fail bytes_checked: expected %0d, actual %0d",
                     BYTES_TO_SCORE, bytes_checked);
        end
        total = data_errs + timing_errs + idle_errs + assert_fails + byte_errs;
        $display("errors: data %0d, timing %0d, idle %0d, assertion %0d, byte count %0d",
                 data_errs, timing_errs, idle_errs, assert_fails, byte_errs);
        if (total == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    endtask

    initial begin
        int cut_line;
        int pulse_delay;
        int pulse_len;
        s_rstn = 1'b0;
        en_i   = 1'b0;
        void'($urandom(SEED));
        repeat (5) @(negedge cam_pclk_o);
        s_rstn = 1'b1;
        repeat (3) @(negedge cam_pclk_o);
        en_i = 1'b1;

        // frame 2 is cut while href is high on one of its later lines
        wait_vsync_rises(3);
        cut_line    = 1 + $urandom % (VRES - 1);
        pulse_delay = 1 + $urandom % (HREF_CLKS - 4);
        pulse_len   = 2 + $urandom % 19;
        repeat (cut_line + 1) @(posedge cam_href);
        repeat (pulse_delay) @(negedge cam_pclk_o);
        en_i = 1'b0;
        repeat (pulse_len) @(negedge cam_pclk_o);
        en_i = 1'b1;

        wait (frames_done == FRAMES_TO_SCORE);
        repeat (4) @(negedge cam_pclk_o);
        finish_run();
    end

endmodule

// ==== vlog.f ====
logic/cam_pkg.sv
logic/cam_frame_timing.sv
logic/cam_pixel_source.sv
logic/cam_rgb565_packer.sv
logic/cam_sensor_top.sv
verif/cam_sensor_sva.sv
verif/cam_sensor_checker.sv
verif/cam_sensor_tb.sv
